// ==== source/csr_pkg.sv ====
package csr_pkg;

    localparam int WORD_W  = 32;
    localparam int NUM_W   = 14;
    localparam int ECODE_W = 6;
    localparam int ESUB_W  = 9;
    localparam int INT_W   = 12;

    typedef logic [WORD_W-1:0]  csr_word_t;
    typedef logic [NUM_W-1:0]   csr_num_t;
    typedef logic [ECODE_W-1:0] ecode_t;
    typedef logic [ESUB_W-1:0]  esubcode_t;
    // 1:0 software, 9:2 hardware, 11 timer
    typedef logic [INT_W-1:0]   int_vec_t;

    typedef enum logic [1:0] {
        CSR_OP_RD   = 2'd0,
        CSR_OP_WR   = 2'd1,
        CSR_OP_XCHG = 2'd2,
        CSR_OP_ERTN = 2'd3
    } csr_op_e;

    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    localparam ecode_t ECODE_INT = 6'h00;
    localparam ecode_t ECODE_ADE = 6'h08;
    localparam ecode_t ECODE_ALE = 6'h09;
    localparam ecode_t ECODE_SYS = 6'h0b;
    localparam ecode_t ECODE_BRK = 6'h0c;
    localparam ecode_t ECODE_INE = 6'h0d;

    localparam esubcode_t ESUB_ADEF = 9'd0;

    // DA=1, PLV=0, IE=0
    localparam logic [8:0] CRMD_RESET = 9'h008;

    localparam int CRMD_IE       = 2;
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int EENTRY_LSB    = 6;

endpackage

// ==== source/csr_if.sv ====
`timescale 1ns/1ps

interface csr_req_if;
    import csr_pkg::*;

    logic      valid;
    csr_op_e   op;
    csr_num_t  num;
    csr_word_t wdata;
    csr_word_t rdata;
    logic      is_excp;
    ecode_t    ecode;
    esubcode_t esubcode;
    csr_word_t pc;
    csr_word_t badv;
    logic      redir;
    csr_word_t redir_pc;

    modport issue (output valid, op, num, wdata, rdata, is_excp, ecode, esubcode,
                   pc, badv, redir, redir_pc);
    modport stage (input valid, op, num, wdata, rdata, is_excp, ecode, esubcode,
                   pc, badv, redir, redir_pc);
    // held copy, driven by the stage and read by the regfile
    modport commit (output valid, op, num, wdata, rdata, is_excp, ecode, esubcode,
                    pc, badv, redir, redir_pc);
endinterface

interface csr_view_if;
    import csr_pkg::*;

    csr_num_t  rd_num;
    csr_word_t rd_data;
    csr_word_t era;
    csr_word_t eentry;
    logic      int_req;

    modport file (input rd_num, output rd_data, era, eentry, int_req);
    modport issue (output rd_num, input rd_data, era, eentry, int_req);
endinterface

// ==== source/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer #(
    parameter int TIMER_N = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               tcfg_we,
    input  logic [TIMER_N-1:0] tcfg_wdata,
    input  logic               ticlr,
    output logic [TIMER_N-1:0] tcfg,
    output logic [TIMER_N-1:0] tval,
    output logic               ti_flag
);
    import csr_pkg::*;

    logic               en_q;
    logic [TIMER_N-1:0] reload;

    // InitVal is counted in units of four cycles
    assign reload = {tcfg[TIMER_N-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg    <= '0;
            tval    <= '0;
            en_q    <= 1'b0;
            ti_flag <= 1'b0;
        end
        else
        begin
            if (tcfg_we)
                tcfg <= tcfg_wdata;
            en_q <= tcfg[TCFG_EN];

            if (ticlr)
                ti_flag <= 1'b0;
            else if (tcfg[TCFG_EN] && en_q && tval == '0)
                ti_flag <= 1'b1;

            if (tcfg[TCFG_EN] && !en_q)
                tval <= reload;
            else if (!tcfg[TCFG_EN])
                tval <= '0;
            else if (tval == '0)
                tval <= tcfg[TCFG_PERIODIC] ? reload : '1;
            // one-shot parks at all ones
            else if (tval != '1)
                tval <= tval - TIMER_N'(1);
        end
    end

endmodule

// ==== source/csr_issue.sv ====
`timescale 1ns/1ps

module csr_issue (
    input  logic               clk,
    input  logic               rstn,
    input  logic               instr_valid,
    input  csr_pkg::csr_op_e   instr_op,
    input  csr_pkg::csr_num_t  instr_num,
    input  csr_pkg::csr_word_t instr_wdata,
    input  csr_pkg::csr_word_t instr_mask,
    input  csr_pkg::csr_word_t instr_pc,
    input  logic               excp_valid,
    input  csr_pkg::ecode_t    excp_ecode,
    input  csr_pkg::esubcode_t excp_esubcode,
    input  csr_pkg::csr_word_t excp_badv,
    input  logic               stall,
    csr_req_if.issue           req,
    csr_view_if.issue          view,
    input  logic               held_excp
);
    import csr_pkg::*;

    logic      int_take;
    logic      is_excp;
    logic      accept;
    csr_word_t mask;
    csr_word_t resume_pc;

    // interrupts preempt the slot even under stall
    assign int_take = view.int_req && !held_excp;
    assign is_excp  = int_take || (instr_valid && excp_valid);
    assign accept   = int_take || (instr_valid && !stall);

    assign view.rd_num = instr_num;
    assign mask        = (instr_op == CSR_OP_WR) ? '1 : instr_mask;

    always_comb
    begin
        req.valid   = accept;
        req.op      = instr_op;
        req.num     = instr_num;
        req.rdata   = view.rd_data;
        req.wdata   = (view.rd_data & ~mask) | (instr_wdata & mask);
        req.is_excp = is_excp;
        req.badv    = excp_badv;
        if (int_take)
        begin
            req.ecode    = ECODE_INT;
            req.esubcode = '0;
            // no instruction present, resume where the last item left off
            req.pc       = instr_valid ? instr_pc : resume_pc;
        end
        else
        begin
            req.ecode    = excp_ecode;
            req.esubcode = excp_esubcode;
            req.pc       = instr_pc;
            if (excp_ecode == ECODE_ADE && excp_esubcode == ESUB_ADEF)
                req.badv = instr_pc;
        end
        req.redir = is_excp || (instr_op != CSR_OP_RD);
        if (is_excp)
            req.redir_pc = view.eentry;
        else if (instr_op == CSR_OP_ERTN)
            req.redir_pc = view.era;
        else
            req.redir_pc = instr_pc + 32'd4;
    end

    // pc of the next instruction in program order
    always_ff @(posedge clk)
    begin
        if (!rstn)
            resume_pc <= '0;
        else if (accept)
            resume_pc <= req.redir ? req.redir_pc : instr_pc + 32'd4;
    end

endmodule

// ==== source/csr_commit_stage.sv ====
`timescale 1ns/1ps

module csr_commit_stage (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               flush,
    csr_req_if.stage           req,
    csr_req_if.commit          held,
    output logic               held_excp,
    output csr_pkg::csr_word_t rdata,
    output csr_pkg::csr_word_t redirect_pc,
    output logic               redirect,
    output logic               excp_flush,
    output logic               ertn_flush
);
    import csr_pkg::*;

    logic int_taken;
    logic load;

    assign int_taken = req.valid && req.is_excp && (req.ecode == ECODE_INT);
    assign load      = req.valid && (!stall || int_taken);

    // valid lasts one cycle per item, so each item commits once
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            held.valid    <= 1'b0;
            held.rdata    <= '0;
            held.redir_pc <= '0;
        end
        else if (flush && !int_taken)
            held.valid <= 1'b0;
        else if (load)
        begin
            held.valid    <= 1'b1;
            held.rdata    <= req.rdata;
            held.redir_pc <= req.redir_pc;
        end
        else
            held.valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            held.op       <= req.op;
            held.num      <= req.num;
            held.wdata    <= req.wdata;
            held.is_excp  <= req.is_excp;
            held.ecode    <= req.ecode;
            held.esubcode <= req.esubcode;
            held.pc       <= req.pc;
            held.badv     <= req.badv;
            held.redir    <= req.redir;
        end
    end

    assign rdata       = held.rdata;
    assign redirect_pc = held.redir_pc;
    assign redirect    = held.valid && held.redir;
    assign excp_flush  = held.valid && held.is_excp;
    assign ertn_flush  = held.valid && !held.is_excp && (held.op == CSR_OP_ERTN);
    assign held_excp   = excp_flush;

endmodule

// ==== source/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile #(
    parameter int TIMER_N = 32
) (
    input  logic       clk,
    input  logic       rstn,
    csr_req_if.commit  held,
    csr_view_if.file   view,
    input  logic [7:0] hw_int,
    output logic [8:0] crmd
);
    import csr_pkg::*;

    logic [8:0]                 crmd_q;
    logic [2:0]                 prmd_q;
    logic [12:0]                ecfg_q;
    logic [1:0]                 estat_is;
    ecode_t                     estat_ecode;
    esubcode_t                  estat_esub;
    csr_word_t                  era_q;
    csr_word_t                  badv_q;
    logic [WORD_W-1:EENTRY_LSB] eentry_q;
    csr_word_t                  save_q [4];
    logic [TIMER_N-1:0]         tcfg;
    logic [TIMER_N-1:0]         tval;
    logic                       ti_flag;
    int_vec_t                   pending;
    logic                       wr_en;
    logic                       excp_en;
    logic                       ertn_en;

    assign wr_en   = held.valid && !held.is_excp &&
                     (held.op == CSR_OP_WR || held.op == CSR_OP_XCHG);
    assign excp_en = held.valid && held.is_excp;
    assign ertn_en = held.valid && !held.is_excp && (held.op == CSR_OP_ERTN);

    csr_timer #(.TIMER_N(TIMER_N)) u_timer (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_we    (wr_en && held.num == CSR_TCFG),
        .tcfg_wdata (held.wdata[TIMER_N-1:0]),
        .ticlr      (wr_en && held.num == CSR_TICLR && held.wdata[0]),
        .tcfg       (tcfg),
        .tval       (tval),
        .ti_flag    (ti_flag)
    );

    // bit 10 stays zero
    assign pending      = {ti_flag, 1'b0, hw_int, estat_is};
    assign view.int_req = (|(pending & ecfg_q[11:0])) && crmd_q[CRMD_IE];
    assign view.era     = era_q;
    assign view.eentry  = {eentry_q, {EENTRY_LSB{1'b0}}};
    assign crmd         = crmd_q;

    always_comb
    begin
        case (view.rd_num)
            CSR_CRMD:   view.rd_data = {23'b0, crmd_q};
            CSR_PRMD:   view.rd_data = {29'b0, prmd_q};
            CSR_ECFG:   view.rd_data = {19'b0, ecfg_q};
            CSR_ESTAT:  view.rd_data = {1'b0, estat_esub, estat_ecode, 4'b0, pending};
            CSR_ERA:    view.rd_data = era_q;
            CSR_BADV:   view.rd_data = badv_q;
            CSR_EENTRY: view.rd_data = {eentry_q, {EENTRY_LSB{1'b0}}};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                view.rd_data = save_q[view.rd_num[1:0]];
            CSR_TCFG:   view.rd_data = csr_word_t'(tcfg);
            CSR_TVAL:   view.rd_data = csr_word_t'(tval);
            default:    view.rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q      <= CRMD_RESET;
            prmd_q      <= '0;
            ecfg_q      <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            eentry_q    <= '0;
            save_q      <= '{default: '0};
        end
        else if (excp_en)
        begin
            prmd_q      <= crmd_q[2:0];
            crmd_q[2:0] <= 3'b000;
            era_q       <= held.pc;
            estat_ecode <= held.ecode;
            estat_esub  <= held.esubcode;
            if (held.ecode == ECODE_ALE ||
                (held.ecode == ECODE_ADE && held.esubcode == ESUB_ADEF))
                badv_q <= held.badv;
        end
        else if (ertn_en)
            crmd_q[2:0] <= prmd_q;
        else if (wr_en)
        begin
            case (held.num)
                CSR_CRMD:
                begin
                    crmd_q[2:0] <= held.wdata[2:0];
                    crmd_q[8:5] <= held.wdata[8:5];
                    // DA and PG only change to a legal pair
                    if (held.wdata[4] ^ held.wdata[3])
                        crmd_q[4:3] <= held.wdata[4:3];
                end
                CSR_PRMD:   prmd_q <= held.wdata[2:0];
                CSR_ECFG:
                begin
                    ecfg_q[12:11] <= held.wdata[12:11];
                    ecfg_q[9:0]   <= held.wdata[9:0];
                end
                CSR_ESTAT:  estat_is <= held.wdata[1:0];
                CSR_ERA:    era_q <= held.wdata;
                CSR_BADV:   badv_q <= held.wdata;
                CSR_EENTRY: eentry_q <= held.wdata[WORD_W-1:EENTRY_LSB];
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                    save_q[held.num[1:0]] <= held.wdata;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit #(
    parameter int TIMER_N = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               instr_valid,
    input  csr_pkg::csr_op_e   instr_op,
    input  csr_pkg::csr_num_t  instr_num,
    input  csr_pkg::csr_word_t instr_wdata,
    input  csr_pkg::csr_word_t instr_mask,
    input  csr_pkg::csr_word_t instr_pc,
    input  logic               excp_valid,
    input  csr_pkg::ecode_t    excp_ecode,
    input  csr_pkg::esubcode_t excp_esubcode,
    input  csr_pkg::csr_word_t excp_badv,
    input  logic [7:0]         hw_int,
    input  logic               stall,
    input  logic               flush,
    output csr_pkg::csr_word_t rdata,
    output logic               redirect,
    output csr_pkg::csr_word_t redirect_pc,
    output logic               excp_flush,
    output logic               ertn_flush,
    output logic [8:0]         crmd
);

    logic held_excp;

    csr_req_if  u_req ();
    csr_req_if  u_held ();
    csr_view_if u_view ();

    csr_issue u_issue (
        .clk           (clk),
        .rstn          (rstn),
        .instr_valid   (instr_valid),
        .instr_op      (instr_op),
        .instr_num     (instr_num),
        .instr_wdata   (instr_wdata),
        .instr_mask    (instr_mask),
        .instr_pc      (instr_pc),
        .excp_valid    (excp_valid),
        .excp_ecode    (excp_ecode),
        .excp_esubcode (excp_esubcode),
        .excp_badv     (excp_badv),
        .stall         (stall),
        .req           (u_req.issue),
        .view          (u_view.issue),
        .held_excp     (held_excp)
    );

    csr_commit_stage u_stage (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush       (flush),
        .req         (u_req.stage),
        .held        (u_held.commit),
        .held_excp   (held_excp),
        .rdata       (rdata),
        .redirect_pc (redirect_pc),
        .redirect    (redirect),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush)
    );

    csr_regfile #(.TIMER_N(TIMER_N)) u_regfile (
        .clk    (clk),
        .rstn   (rstn),
        .held   (u_held.commit),
        .view   (u_view.file),
        .hw_int (hw_int),
        .crmd   (crmd)
    );

endmodule

// ==== bench/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam int        N_RAND          = 20;
    localparam int        N_ITEMS         = 110;
    localparam int        TIMER_CYCLES    = 128;
    localparam int        WATCHDOG_CYCLES = N_ITEMS * 200 + TIMER_CYCLES * 4;
    localparam csr_word_t TCFG_ONESHOT    = 32'h0000_0081;

    logic       clk;
    logic       rstn;
    logic       instr_valid;
    csr_op_e    instr_op;
    csr_num_t   instr_num;
    csr_word_t  instr_wdata;
    csr_word_t  instr_mask;
    csr_word_t  instr_pc;
    logic       excp_valid;
    ecode_t     excp_ecode;
    esubcode_t  excp_esubcode;
    csr_word_t  excp_badv;
    logic [7:0] hw_int;
    logic       stall;
    logic       flush;
    csr_word_t  rdata;
    logic       redirect;
    csr_word_t  redirect_pc;
    logic       excp_flush;
    logic       ertn_flush;
    logic [8:0] crmd;

    // reference copy of the kept CSRs
    logic [8:0]  m_crmd;
    logic [2:0]  m_prmd;
    logic [12:0] m_ecfg;
    logic [1:0]  m_is;
    ecode_t      m_ecode;
    esubcode_t   m_esub;
    csr_word_t   m_era;
    csr_word_t   m_badv;
    csr_word_t   m_eentry;
    csr_word_t   m_save [4];
    csr_word_t   m_tcfg;
    logic        m_ti;

    csr_word_t rng;
    csr_word_t cur_pc;
    csr_word_t next_pc;
    int        issued;
    int        errors;
    int        checks;
    logic      polling;
    logic      exp_redirect;
    logic      exp_excp;
    logic      exp_ertn;
    logic      chk_rdata;
    csr_word_t exp_rpc;
    csr_word_t exp_rdata;
    csr_num_t  all_nums [14];

    csr_unit #(.TIMER_N(32)) u_csr_unit (
        .clk           (clk),
        .rstn          (rstn),
        .instr_valid   (instr_valid),
        .instr_op      (instr_op),
        .instr_num     (instr_num),
        .instr_wdata   (instr_wdata),
        .instr_mask    (instr_mask),
        .instr_pc      (instr_pc),
        .excp_valid    (excp_valid),
        .excp_ecode    (excp_ecode),
        .excp_esubcode (excp_esubcode),
        .excp_badv     (excp_badv),
        .hw_int        (hw_int),
        .stall         (stall),
        .flush         (flush),
        .rdata         (rdata),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .excp_flush    (excp_flush),
        .ertn_flush    (ertn_flush),
        .crmd          (crmd)
    );

    always #5 clk = ~clk;

    function automatic csr_word_t lcg_next(input csr_word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic csr_word_t rand32();
        rng = lcg_next(rng);
        return rng;
    endfunction

    // TVAL is only read while the timer is off
    function automatic csr_word_t ref_read(input csr_num_t num);
        case (num)
            CSR_CRMD:   return {23'b0, m_crmd};
            CSR_PRMD:   return {29'b0, m_prmd};
            CSR_ECFG:   return {19'b0, m_ecfg};
            CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 4'b0, m_ti, 1'b0, hw_int, m_is};
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                return m_save[num[1:0]];
            CSR_TCFG:   return m_tcfg;
            default:    return '0;
        endcase
    endfunction

    // returns the old value and advances the reference state
    function automatic csr_word_t ref_apply(input csr_op_e op, input csr_num_t num,
                                            input csr_word_t wd, input csr_word_t mk,
                                            input logic exc, input ecode_t ec,
                                            input esubcode_t es, input csr_word_t bv,
                                            input csr_word_t pc);
        csr_word_t old;
        csr_word_t m;
        csr_word_t v;
        old = ref_read(num);
        m   = (op == CSR_OP_WR) ? '1 : mk;
        v   = (old & ~m) | (wd & m);
        if (exc)
        begin
            m_prmd      = m_crmd[2:0];
            m_crmd[2:0] = 3'b000;
            m_era       = pc;
            m_ecode     = ec;
            m_esub      = es;
            if (ec == ECODE_ALE)
                m_badv = bv;
            else if (ec == ECODE_ADE && es == ESUB_ADEF)
                m_badv = pc;
        end
        else if (op == CSR_OP_ERTN)
            m_crmd[2:0] = m_prmd;
        else if (op != CSR_OP_RD)
        begin
            case (num)
                CSR_CRMD:
                begin
                    m_crmd[2:0] = v[2:0];
                    m_crmd[8:5] = v[8:5];
                    if (v[4] != v[3])
                        m_crmd[4:3] = v[4:3];
                end
                CSR_PRMD:   m_prmd = v[2:0];
                CSR_ECFG:   m_ecfg = {v[12:11], 1'b0, v[9:0]};
                CSR_ESTAT:  m_is = v[1:0];
                CSR_ERA:    m_era = v;
                CSR_BADV:   m_badv = v;
                CSR_EENTRY: m_eentry = {v[31:6], 6'b0};
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                    m_save[num[1:0]] = v;
                CSR_TCFG:   m_tcfg = v;
                CSR_TICLR:
                begin
                    if (v[0])
                        m_ti = 1'b0;
                end
                default: ;
            endcase
        end
        return old;
    endfunction

    task automatic report_mismatch(input string name, input csr_word_t exp,
                                   input csr_word_t act);
        $display("FAILED %s expected %h actual %h", name, exp, act);
        errors = errors + 1;
    endtask

    task automatic run_item(input csr_op_e op, input csr_num_t num, input csr_word_t wd,
                            input csr_word_t mk, input logic exc, input ecode_t ec,
                            input esubcode_t es, input csr_word_t bv, input int n_stall,
                            input logic fl);
        csr_word_t old;
        csr_word_t rpc;
        cur_pc = cur_pc + 32'h10;
        issued = issued + 1;
        @(posedge clk);
        instr_valid   <= 1'b1;
        instr_op      <= op;
        instr_num     <= num;
        instr_wdata   <= wd;
        instr_mask    <= mk;
        instr_pc      <= cur_pc;
        excp_valid    <= exc;
        excp_ecode    <= ec;
        excp_esubcode <= es;
        excp_badv     <= bv;
        stall         <= (n_stall > 0);
        flush         <= fl;
        repeat (n_stall) @(posedge clk);
        if (n_stall > 0)
            stall <= 1'b0;
        if (exc)
            rpc = m_eentry;
        else if (op == CSR_OP_ERTN)
            rpc = m_era;
        else
            rpc = cur_pc + 32'd4;
        next_pc = rpc;
        if (fl)
            old = ref_read(num);
        else
            old = ref_apply(op, num, wd, mk, exc, ec, es, bv, cur_pc);
        @(posedge clk);
        instr_valid <= 1'b0;
        excp_valid  <= 1'b0;
        flush       <= 1'b0;
        if (!fl)
        begin
            exp_rdata    = old;
            chk_rdata    = !exc && op != CSR_OP_ERTN;
            exp_redirect = exc || op != CSR_OP_RD;
            exp_rpc      = rpc;
            exp_excp     = exc;
            exp_ertn     = !exc && op == CSR_OP_ERTN;
        end
        @(posedge clk);
        exp_redirect = 1'b0;
        exp_excp     = 1'b0;
        exp_ertn     = 1'b0;
        chk_rdata    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (crmd !== m_crmd)
            report_mismatch("crmd", {23'b0, m_crmd}, {23'b0, crmd});
    endtask

    task automatic csr_rd(input csr_num_t num);
        run_item(CSR_OP_RD, num, '0, '0, 1'b0, ECODE_INT, '0, '0, 0, 1'b0);
    endtask

    task automatic csr_wr(input csr_op_e op, input csr_num_t num, input csr_word_t wd,
                          input csr_word_t mk);
        run_item(op, num, wd, mk, 1'b0, ECODE_INT, '0, '0, 0, 1'b0);
    endtask

    // the instruction fields ask for a SAVE2 write, the exception must win
    task automatic excp_case(input ecode_t ec, input esubcode_t es, input csr_word_t bv);
        csr_wr(CSR_OP_WR, CSR_CRMD, 32'h0000_000b, '1);
        run_item(CSR_OP_WR, CSR_SAVE2, rand32(), '1, 1'b1, ec, es, bv, 0, 1'b0);
        csr_rd(CSR_ERA);
        csr_rd(CSR_PRMD);
        csr_rd(CSR_CRMD);
        csr_rd(CSR_ESTAT);
        csr_rd(CSR_BADV);
        csr_rd(CSR_SAVE2);
    endtask

    always @(negedge clk)
    begin
        if (rstn && !polling)
        begin
            checks = checks + 1;
            if (redirect !== exp_redirect)
                report_mismatch("redirect", {31'b0, exp_redirect}, {31'b0, redirect});
            if (excp_flush !== exp_excp)
                report_mismatch("excp_flush", {31'b0, exp_excp}, {31'b0, excp_flush});
            if (ertn_flush !== exp_ertn)
                report_mismatch("ertn_flush", {31'b0, exp_ertn}, {31'b0, ertn_flush});
            if (exp_redirect && redirect_pc !== exp_rpc)
                report_mismatch("redirect_pc", exp_rpc, redirect_pc);
            if (chk_rdata && rdata !== exp_rdata)
                report_mismatch("rdata", exp_rdata, rdata);
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        csr_num_t  num;
        csr_word_t tmp;
        csr_word_t wd;
        clk = 1'b0;
        rstn = 1'b0;
        instr_valid = 1'b0;
        instr_op = CSR_OP_RD;
        instr_num = '0;
        instr_wdata = '0;
        instr_mask = '0;
        instr_pc = '0;
        excp_valid = 1'b0;
        excp_ecode = '0;
        excp_esubcode = '0;
        excp_badv = '0;
        hw_int = '0;
        stall = 1'b0;
        flush = 1'b0;
        m_crmd = 9'h008;
        m_prmd = '0;
        m_ecfg = '0;
        m_is = '0;
        m_ecode = '0;
        m_esub = '0;
        m_era = '0;
        m_badv = '0;
        m_eentry = '0;
        m_save = '{default: '0};
        m_tcfg = '0;
        m_ti = 1'b0;
        rng = 32'h2310_a0f2;
        cur_pc = 32'h1c00_0000;
        next_pc = '0;
        issued = 0;
        errors = 0;
        checks = 0;
        polling = 1'b0;
        exp_redirect = 1'b0;
        exp_excp = 1'b0;
        exp_ertn = 1'b0;
        chk_rdata = 1'b0;
        exp_rpc = '0;
        exp_rdata = '0;
        // first eleven take random writes
        all_nums = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV,
                     CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                     CSR_TCFG, CSR_TVAL, CSR_TICLR};

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if (rdata !== '0)
            report_mismatch("rdata", '0, rdata);
        if (crmd !== 9'h008)
            report_mismatch("crmd", 32'h0000_0008, {23'b0, crmd});
        foreach (all_nums[i])
            csr_rd(all_nums[i]);

        // random read-modify-write, IE kept low
        repeat (N_RAND)
        begin
            num = all_nums[int'(rand32() % 32'd11)];
            wd  = rand32();
            tmp = rand32();
            if (num == CSR_CRMD)
                wd[2] = 1'b0;
            csr_wr(tmp[0] ? CSR_OP_XCHG : CSR_OP_WR, num, wd, rand32());
            csr_rd(num);
        end
        csr_wr(CSR_OP_WR, CSR_ECFG, '0, '1);
        csr_wr(CSR_OP_WR, CSR_ESTAT, '0, '1);

        run_item(CSR_OP_XCHG, CSR_SAVE1, rand32(), rand32(), 1'b0, ECODE_INT, '0, '0, 4, 1'b0);
        csr_rd(CSR_SAVE1);
        run_item(CSR_OP_WR, CSR_SAVE0, rand32(), '1, 1'b0, ECODE_INT, '0, '0, 0, 1'b1);
        csr_rd(CSR_SAVE0);

        csr_wr(CSR_OP_WR, CSR_EENTRY, 32'h1c00_8000, '1);
        excp_case(ECODE_SYS, '0, 32'h1234_5678);
        excp_case(ECODE_ALE, '0, 32'hbad0_0012);
        excp_case(ECODE_ADE, ESUB_ADEF, 32'h5555_aaaa);
        run_item(CSR_OP_ERTN, '0, '0, '0, 1'b0, ECODE_INT, '0, '0, 0, 1'b0);
        csr_rd(CSR_CRMD);

        // one-shot timer with only LIE bit 11 enabled
        csr_wr(CSR_OP_WR, CSR_ECFG, 32'h0000_0800, '1);
        csr_wr(CSR_OP_WR, CSR_CRMD, 32'h0000_000c, '1);
        csr_wr(CSR_OP_WR, CSR_TCFG, TCFG_ONESHOT, '1);
        polling = 1'b1;
        @(negedge clk);
        while (excp_flush !== 1'b1)
            @(negedge clk);
        if (redirect !== 1'b1)
            report_mismatch("redirect", 32'h1, {31'b0, redirect});
        if (redirect_pc !== m_eentry)
            report_mismatch("redirect_pc", m_eentry, redirect_pc);
        void'(ref_apply(CSR_OP_RD, CSR_CRMD, '0, '0, 1'b1, ECODE_INT, '0, '0, next_pc));
        m_ti = 1'b1;
        @(posedge clk);
        polling = 1'b0;
        csr_rd(CSR_ERA);
        csr_rd(CSR_PRMD);
        csr_rd(CSR_ESTAT);
        csr_wr(CSR_OP_WR, CSR_TICLR, 32'h0000_0001, '1);
        csr_rd(CSR_ESTAT);
        csr_wr(CSR_OP_WR, CSR_TCFG, '0, '1);
        csr_rd(CSR_TVAL);
        csr_rd(CSR_TCFG);

        repeat (2) @(posedge clk);
        $display("checks %0d, items %0d, errors %0d", checks, issued, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
source/csr_pkg.sv
source/csr_if.sv
source/csr_timer.sv
source/csr_issue.sv
source/csr_commit_stage.sv
source/csr_regfile.sv
source/csr_unit.sv
bench/csr_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module csr_unit_tb -o csr_unit_tb
./obj_dir/csr_unit_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"
